//--- load_align.sv
`timescale 1ns/1ps

module load_align (
    input  logic [wb_pkg::xlen-1:0]    mem_data,
    input  logic [wb_pkg::rstrb_w-1:0] mem_rstrb,
    input  logic [wb_pkg::shamt_w-1:0] mem_shamt,
    output logic [wb_pkg::xlen-1:0]    load_data
);

    logic [wb_pkg::xlen-1:0] shifted;
    wb_pkg::load_word_u      view;
    logic [7:0]              mask;
    logic                    sign;

    // bring the addressed byte down to byte 0
    assign shifted = mem_data >> {mem_shamt, 3'b000};
    assign view    = shifted;

    assign mask = mem_rstrb[7:0];
    assign sign = mem_rstrb[wb_pkg::rstrb_sign];

    always_comb begin
        case (mask)
            wb_pkg::mask_byte: begin
                if (sign) begin
                    load_data = {{(wb_pkg::xlen-8){view.b[0][7]}}, view.b[0]};
                end else begin
                    load_data = {{(wb_pkg::xlen-8){1'b0}}, view.b[0]};
                end
            end
            wb_pkg::mask_half: begin
                if (sign) begin
                    load_data = {{(wb_pkg::xlen-16){view.h[0][15]}}, view.h[0]};
                end else begin
                    load_data = {{(wb_pkg::xlen-16){1'b0}}, view.h[0]};
                end
            end
            wb_pkg::mask_word: begin
                // lw sign-extends and lwu does not
                if (sign) begin
                    load_data = {{(wb_pkg::xlen-32){view.w[0][31]}}, view.w[0]};
                end else begin
                    load_data = {{(wb_pkg::xlen-32){1'b0}}, view.w[0]};
                end
            end
            wb_pkg::mask_dword: begin
                load_data = shifted;    // full width so extension has nothing to add
            end
            default: begin
                load_data = '0;         // malformed strobe loads nothing
            end
        endcase
    end

endmodule

//--- mem_wb_reg.sv
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                          I_sys_clk,
    input  logic                          I_rst,
    input  logic                          in_valid,
    output logic                          allowin,
    output logic                          out_valid,
    input  logic [wb_pkg::xlen-1:0]       pc,
    input  logic [wb_pkg::xlen-1:0]       mem_data,
    input  logic [wb_pkg::rstrb_w-1:0]    mem_rstrb,
    input  logic [wb_pkg::shamt_w-1:0]    mem_shamt,
    input  logic [wb_pkg::xlen-1:0]       alu_out,
    input  logic                          reg_wen,
    input  logic [wb_pkg::reg_addr_w-1:0] rd_addr,
    input  logic [wb_pkg::sel_w-1:0]      regin_sel,
    input  logic [wb_pkg::inst_w-1:0]     inst_debug,
    input  logic                          bubble_debug,
    output logic [wb_pkg::xlen-1:0]       q_pc,
    output logic [wb_pkg::xlen-1:0]       q_mem_data,
    output logic [wb_pkg::rstrb_w-1:0]    q_mem_rstrb,
    output logic [wb_pkg::shamt_w-1:0]    q_mem_shamt,
    output logic [wb_pkg::xlen-1:0]       q_alu_out,
    output logic                          q_reg_wen,
    output logic [wb_pkg::reg_addr_w-1:0] q_rd_addr,
    output logic [wb_pkg::sel_w-1:0]      q_regin_sel,
    output logic [wb_pkg::inst_w-1:0]     q_inst_debug,
    output logic                          q_bubble_debug
);

    logic valid_q;
    logic load_en;

    // writeback retires whatever it holds every cycle so the output side is always ready
    assign out_valid = valid_q;
    assign allowin   = !valid_q || out_valid;
    assign load_en   = allowin && in_valid;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            valid_q <= 1'b0;
        end else if (allowin) begin
            valid_q <= in_valid;     // an idle cycle drops the flag
        end
    end

    // fields only move when a new instruction is accepted
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            q_pc           <= '0;
            q_mem_data     <= '0;
            q_mem_rstrb    <= '0;
            q_mem_shamt    <= '0;
            q_alu_out      <= '0;
            q_reg_wen      <= 1'b0;
            q_rd_addr      <= '0;
            q_regin_sel    <= '0;
            q_inst_debug   <= '0;
            q_bubble_debug <= 1'b0;
        end else if (load_en) begin
            q_pc           <= pc;
            q_mem_data     <= mem_data;
            q_mem_rstrb    <= mem_rstrb;
            q_mem_shamt    <= mem_shamt;
            q_alu_out      <= alu_out;
            q_reg_wen      <= reg_wen;
            q_rd_addr      <= rd_addr;
            q_regin_sel    <= regin_sel;
            q_inst_debug   <= inst_debug;
            q_bubble_debug <= bubble_debug;
        end
    end

endmodule

//--- wb_pkg.sv
package wb_pkg;

    // RV64 integer data and register address widths
    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;
    localparam int inst_w     = 32;

    // one-hot writeback source select
    localparam int sel_w    = 3;
    localparam int sel_alu  = 0;      // ALU result
    localparam int sel_mem  = 1;      // aligned load data
    localparam int sel_link = 2;      // pc plus link offset

    // read strobe has a byte mask in bits 7..0 and the sign flag on top
    localparam int rstrb_w    = 9;
    localparam int rstrb_sign = 8;
    localparam int shamt_w    = 3;

    // the only byte masks a load may carry
    localparam logic [7:0] mask_byte  = 8'h01;
    localparam logic [7:0] mask_half  = 8'h03;
    localparam logic [7:0] mask_word  = 8'h0f;
    localparam logic [7:0] mask_dword = 8'hff;

    // return address offset for jal and jalr
    localparam logic [xlen-1:0] link_offset = 64'd4;

    // one memory word seen as bytes, halves or words
    typedef union packed {
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
    } load_word_u;

endpackage

//--- wb_regfile.sv
`timescale 1ns/1ps

module wb_regfile (
    input  logic                          I_sys_clk,
    input  logic                          I_rst,
    input  logic                          valid,
    input  logic [wb_pkg::xlen-1:0]       pc,
    input  logic [wb_pkg::xlen-1:0]       alu_out,
    input  logic [wb_pkg::xlen-1:0]       load_data,
    input  logic                          reg_wen,
    input  logic [wb_pkg::reg_addr_w-1:0] rd_addr,
    input  logic [wb_pkg::sel_w-1:0]      regin_sel,
    input  logic [wb_pkg::inst_w-1:0]     inst_debug,
    input  logic                          bubble_debug,
    input  logic [wb_pkg::reg_addr_w-1:0] rs_addr,
    output logic [wb_pkg::xlen-1:0]       rs_data,
    output logic                          retire_valid,
    output logic [wb_pkg::xlen-1:0]       retire_pc,
    output logic [wb_pkg::inst_w-1:0]     retire_inst,
    output logic [wb_pkg::reg_addr_w-1:0] retire_rd,
    output logic [wb_pkg::xlen-1:0]       retire_data,
    output logic                          retire_wen
);

    localparam int nregs = 2 ** wb_pkg::reg_addr_w;

    logic [wb_pkg::xlen-1:0] regs [nregs];
    logic [wb_pkg::xlen-1:0] link_data;
    logic [wb_pkg::xlen-1:0] wb_data;
    logic                    wen;

    assign link_data = pc + wb_pkg::link_offset;

    // the select is one-hot so an and-or mux is enough and an empty select gives zero
    always_comb begin
        wb_data = '0;
        if (regin_sel[wb_pkg::sel_alu]) begin
            wb_data = wb_data | alu_out;
        end
        if (regin_sel[wb_pkg::sel_mem]) begin
            wb_data = wb_data | load_data;
        end
        if (regin_sel[wb_pkg::sel_link]) begin
            wb_data = wb_data | link_data;
        end
    end

    // x0 is never written so it keeps its reset value of zero
    assign wen = valid && reg_wen && (rd_addr != '0);

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[rd_addr] <= wb_data;
        end
    end

    assign rs_data = regs[rs_addr];   // no bypass so a same-cycle write shows up next cycle

    // trace follows the pipeline register directly
    assign retire_valid = valid && !bubble_debug;
    assign retire_pc    = pc;
    assign retire_inst  = inst_debug;
    assign retire_rd    = rd_addr;
    assign retire_data  = wb_data;
    assign retire_wen   = wen;

endmodule

//--- wb_stage.f
wb_pkg.sv
mem_wb_reg.sv
load_align.sv
wb_regfile.sv
wb_stage.sv
wb_stage_tb.sv

//--- wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                          I_sys_clk,
    input  logic                          I_rst,
    input  logic                          in_valid,
    input  logic [wb_pkg::xlen-1:0]       pc,
    input  logic [wb_pkg::xlen-1:0]       mem_data,
    input  logic [wb_pkg::rstrb_w-1:0]    mem_rstrb,
    input  logic [wb_pkg::shamt_w-1:0]    mem_shamt,
    input  logic [wb_pkg::xlen-1:0]       alu_out,
    input  logic                          reg_wen,
    input  logic [wb_pkg::reg_addr_w-1:0] rd_addr,
    input  logic [wb_pkg::sel_w-1:0]      regin_sel,
    input  logic [wb_pkg::inst_w-1:0]     inst_debug,
    input  logic                          bubble_debug,
    output logic                          allowin,
    output logic                          pipe_valid,
    input  logic [wb_pkg::reg_addr_w-1:0] rs_addr,
    output logic [wb_pkg::xlen-1:0]       rs_data,
    output logic                          retire_valid,
    output logic [wb_pkg::xlen-1:0]       retire_pc,
    output logic [wb_pkg::inst_w-1:0]     retire_inst,
    output logic [wb_pkg::reg_addr_w-1:0] retire_rd,
    output logic [wb_pkg::xlen-1:0]       retire_data,
    output logic                          retire_wen
);

    logic [wb_pkg::xlen-1:0]       q_pc;
    logic [wb_pkg::xlen-1:0]       q_mem_data;
    logic [wb_pkg::rstrb_w-1:0]    q_mem_rstrb;
    logic [wb_pkg::shamt_w-1:0]    q_mem_shamt;
    logic [wb_pkg::xlen-1:0]       q_alu_out;
    logic                          q_reg_wen;
    logic [wb_pkg::reg_addr_w-1:0] q_rd_addr;
    logic [wb_pkg::sel_w-1:0]      q_regin_sel;
    logic [wb_pkg::inst_w-1:0]     q_inst_debug;
    logic                          q_bubble_debug;
    logic [wb_pkg::xlen-1:0]       load_data;

    mem_wb_reg u_mem_wb_reg (
        .I_sys_clk      (I_sys_clk),
        .I_rst          (I_rst),
        .in_valid       (in_valid),
        .allowin        (allowin),
        .out_valid      (pipe_valid),
        .pc             (pc),
        .mem_data       (mem_data),
        .mem_rstrb      (mem_rstrb),
        .mem_shamt      (mem_shamt),
        .alu_out        (alu_out),
        .reg_wen        (reg_wen),
        .rd_addr        (rd_addr),
        .regin_sel      (regin_sel),
        .inst_debug     (inst_debug),
        .bubble_debug   (bubble_debug),
        .q_pc           (q_pc),
        .q_mem_data     (q_mem_data),
        .q_mem_rstrb    (q_mem_rstrb),
        .q_mem_shamt    (q_mem_shamt),
        .q_alu_out      (q_alu_out),
        .q_reg_wen      (q_reg_wen),
        .q_rd_addr      (q_rd_addr),
        .q_regin_sel    (q_regin_sel),
        .q_inst_debug   (q_inst_debug),
        .q_bubble_debug (q_bubble_debug)
    );

    load_align u_load_align (
        .mem_data  (q_mem_data),
        .mem_rstrb (q_mem_rstrb),
        .mem_shamt (q_mem_shamt),
        .load_data (load_data)
    );

    wb_regfile u_wb_regfile (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .valid        (pipe_valid),
        .pc           (q_pc),
        .alu_out      (q_alu_out),
        .load_data    (load_data),
        .reg_wen      (q_reg_wen),
        .rd_addr      (q_rd_addr),
        .regin_sel    (q_regin_sel),
        .inst_debug   (q_inst_debug),
        .bubble_debug (q_bubble_debug),
        .rs_addr      (rs_addr),
        .rs_data      (rs_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .retire_wen   (retire_wen)
    );

endmodule

//--- wb_stage_tb.sv
`timescale 1ns/1ps

module wb_stage_tb;

    localparam int timeout_cycles = 20;
    localparam logic [2:0] alu_sel  = 3'b001 << wb_pkg::sel_alu;
    localparam logic [2:0] mem_sel  = 3'b001 << wb_pkg::sel_mem;
    localparam logic [2:0] link_sel = 3'b001 << wb_pkg::sel_link;

    logic        I_sys_clk;
    logic        I_rst;
    logic        in_valid;
    logic [63:0] pc;
    logic [63:0] mem_data;
    logic [8:0]  mem_rstrb;
    logic [2:0]  mem_shamt;
    logic [63:0] alu_out;
    logic        reg_wen;
    logic [4:0]  rd_addr;
    logic [2:0]  regin_sel;
    logic [31:0] inst_debug;
    logic        bubble_debug;
    logic        allowin;
    logic        pipe_valid;
    logic [4:0]  rs_addr;
    logic [63:0] rs_data;
    logic        retire_valid;
    logic [63:0] retire_pc;
    logic [31:0] retire_inst;
    logic [4:0]  retire_rd;
    logic [63:0] retire_data;
    logic        retire_wen;

    logic [31:0] lcg_state;
    logic [63:0] shadow [32];        // expected register file contents
    logic [63:0] exp_pc_q [$];
    logic [31:0] exp_inst_q [$];
    logic [4:0]  exp_rd_q [$];
    logic [63:0] exp_data_q [$];

    wb_stage u_wb_stage (.*);

    always #5 I_sys_clk = ~I_sys_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        hi = lcg_next();
        return {hi, lcg_next()};
    endfunction

    function automatic logic [7:0] legal_mask(input logic [1:0] k);
        case (k)
            2'd0: return 8'h01;
            2'd1: return 8'h03;
            2'd2: return 8'h0f;
            default: return 8'hff;
        endcase
    endfunction

    // shift down, keep the masked field, then widen it
    function automatic logic [63:0] exp_load(input logic [63:0] data, input logic [8:0] rstrb,
                                             input logic [2:0] shamt);
        logic [63:0] value;
        logic [63:0] field;
        int          width;
        value = data >> (8 * shamt);
        case (rstrb[7:0])
            8'h01: width = 8;
            8'h03: width = 16;
            8'h0f: width = 32;
            8'hff: width = 64;
            default: width = 0;
        endcase
        if (width == 0) return 64'd0;
        if (width == 64) return value;
        field = (64'd1 << width) - 64'd1;
        value = value & field;
        if (rstrb[wb_pkg::rstrb_sign] && value[width-1]) begin
            value = value | ~field;
        end
        return value;
    endfunction

    function automatic logic [63:0] exp_writeback(input logic [2:0] sel, input logic [63:0] alu,
                                                  input logic [63:0] load, input logic [63:0] ipc);
        case (sel)
            alu_sel:  return alu;
            mem_sel:  return load;
            link_sel: return ipc + wb_pkg::link_offset;
            default:  return 64'd0;
        endcase
    endfunction

    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // called just after a falling edge, where allowin is settled
    task automatic wait_allowin();
        int cycles;
        cycles = 0;
        while (!allowin) begin
            @(negedge I_sys_clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("allowin stayed low for too many cycles");
                stop_with_failure();
            end
        end
    endtask

    task automatic drive_instr(input logic [63:0] ipc, input logic [63:0] data,
                               input logic [8:0] rstrb, input logic [2:0] shamt,
                               input logic [63:0] alu, input logic wen, input logic [4:0] rd,
                               input logic [2:0] sel, input logic [31:0] inst, input logic bubble);
        in_valid     <= 1'b1;
        pc           <= ipc;
        mem_data     <= data;
        mem_rstrb    <= rstrb;
        mem_shamt    <= shamt;
        alu_out      <= alu;
        reg_wen      <= wen;
        rd_addr      <= rd;
        regin_sel    <= sel;
        inst_debug   <= inst;
        bubble_debug <= bubble;
    endtask

    // one instruction through capture, retire and read-back
    task automatic write_and_check(input string name, input logic [63:0] ipc,
                                   input logic [63:0] data, input logic [8:0] rstrb,
                                   input logic [2:0] shamt, input logic [63:0] alu,
                                   input logic wen, input logic [4:0] rd, input logic [2:0] sel);
        logic [63:0] exp_data;
        logic [31:0] inst;
        logic        exp_wen;
        inst     = lcg_next();
        exp_data = exp_writeback(sel, alu, exp_load(data, rstrb, shamt), ipc);
        exp_wen  = wen && (rd != 5'd0);
        @(negedge I_sys_clk);
        wait_allowin();
        @(posedge I_sys_clk);
        drive_instr(ipc, data, rstrb, shamt, alu, wen, rd, sel, inst, 1'b0);
        @(posedge I_sys_clk);
        in_valid <= 1'b0;
        rs_addr  <= rd;
        @(negedge I_sys_clk);
        check_value({name, " pipe_valid"}, 64'd1, pipe_valid);
        check_value({name, " retire_valid"}, 64'd1, retire_valid);
        check_value({name, " retire_pc"}, ipc, retire_pc);
        check_value({name, " retire_inst"}, inst, retire_inst);
        check_value({name, " retire_rd"}, rd, retire_rd);
        check_value({name, " retire_data"}, exp_data, retire_data);
        check_value({name, " retire_wen"}, exp_wen, retire_wen);
        if (exp_wen) shadow[rd] = exp_data;
        @(posedge I_sys_clk);
        @(negedge I_sys_clk);
        check_value({name, " idle pipe_valid"}, 64'd0, pipe_valid);   // idle cycle drops it
        check_value({name, " read-back"}, shadow[rd], rs_data);
    endtask

    task automatic read_all_regs(input string name);
        for (int r = 0; r < 32; r++) begin
            @(posedge I_sys_clk);
            rs_addr <= 5'(r);
            @(negedge I_sys_clk);
            check_value(name, shadow[r], rs_data);
        end
    endtask

    task automatic check_retire_step();
        if (retire_valid) begin
            if (exp_pc_q.size() == 0) begin
                $display("retire_valid was high with no instruction left to retire");
                stop_with_failure();
            end
            check_value("stream retire_pc", exp_pc_q.pop_front(), retire_pc);
            check_value("stream retire_inst", exp_inst_q.pop_front(), retire_inst);
            check_value("stream retire_rd", exp_rd_q.pop_front(), retire_rd);
            check_value("stream retire_data", exp_data_q.pop_front(), retire_data);
        end
    endtask

    task automatic test_reset_state();
        @(negedge I_sys_clk);
        check_value("reset allowin", 64'd1, allowin);
        check_value("reset pipe_valid", 64'd0, pipe_valid);
        check_value("reset retire_valid", 64'd0, retire_valid);
        read_all_regs("reset regfile");
    endtask

    task automatic test_alu_writeback();
        logic [4:0] rd;
        for (int i = 0; i < 12; i++) begin
            rd = 5'(1 + (lcg_next() % 31));
            write_and_check("alu_writeback", rand64() & ~64'h3, rand64(), 9'h0ff, 3'd0,
                            rand64(), 1'b1, rd, alu_sel);
        end
    endtask

    task automatic test_load_align();
        logic [4:0] rd;
        for (int m = 0; m < 4; m++) begin
            for (int s = 0; s < 8; s++) begin
                for (int sg = 0; sg < 2; sg++) begin
                    rd = 5'(1 + (lcg_next() % 31));
                    write_and_check("load_align", rand64() & ~64'h3, rand64(),
                                    {sg[0], legal_mask(2'(m))}, s[2:0], rand64(), 1'b1, rd,
                                    mem_sel);
                end
            end
        end
        // fill x9 first so the zero from a bad mask is visible
        write_and_check("load_align prefill", 64'h1000, 64'd0, 9'h0, 3'd0, rand64(), 1'b1,
                        5'd9, alu_sel);
        write_and_check("load_align bad mask", 64'h1004, rand64(), {1'b1, 8'h07}, 3'd1,
                        rand64(), 1'b1, 5'd9, mem_sel);
    endtask

    task automatic test_link_and_x0();
        logic [4:0] rd;
        rd = 5'(1 + (lcg_next() % 31));
        write_and_check("link", rand64() & ~64'h3, 64'd0, 9'h0, 3'd0, rand64(), 1'b1, rd,
                        link_sel);
        write_and_check("x0 write", rand64() & ~64'h3, 64'd0, 9'h0, 3'd0, rand64(), 1'b1,
                        5'd0, alu_sel);
        write_and_check("wen low", rand64() & ~64'h3, 64'd0, 9'h0, 3'd0, rand64(), 1'b0, rd,
                        alu_sel);
    endtask

    task automatic test_back_to_back_and_bubbles();
        logic [63:0] ipc;
        logic [63:0] data;
        logic [63:0] alu;
        logic [63:0] exp_data;
        logic [31:0] inst;
        logic [31:0] r;
        logic [8:0]  rstrb;
        logic [2:0]  sel;
        logic        bubble;
        logic        wen;
        for (int i = 0; i < 80; i++) begin
            @(negedge I_sys_clk);
            check_retire_step();
            wait_allowin();
            @(posedge I_sys_clk);
            r = lcg_next();
            if (r[31:30] == 2'd0) begin
                in_valid <= 1'b0;      // idle gap
            end else begin
                ipc      = rand64() & ~64'h3;
                data     = rand64();
                alu      = rand64();
                inst     = lcg_next();
                rstrb    = {r[0], legal_mask(r[2:1])};
                sel      = 3'b001 << (r[4:3] % 3);
                bubble   = (r[7:5] == 3'd0);
                wen      = !bubble && r[8];   // bubbles never write
                exp_data = exp_writeback(sel, alu, exp_load(data, rstrb, r[16:14]), ipc);
                drive_instr(ipc, data, rstrb, r[16:14], alu, wen, r[13:9], sel, inst, bubble);
                if (!bubble) begin
                    exp_pc_q.push_back(ipc);
                    exp_inst_q.push_back(inst);
                    exp_rd_q.push_back(r[13:9]);
                    exp_data_q.push_back(exp_data);
                end
                if (wen && r[13:9] != 5'd0) shadow[r[13:9]] = exp_data;
            end
        end
        // the instruction before the last one retires in this cycle
        @(negedge I_sys_clk);
        check_retire_step();
        @(posedge I_sys_clk);
        in_valid <= 1'b0;
        repeat (3) begin
            @(negedge I_sys_clk);
            check_retire_step();
        end
        check_value("stream retires left over", 64'd0, exp_pc_q.size());
        read_all_regs("stream final regfile");
    endtask

    initial begin
        I_sys_clk    = 1'b0;
        I_rst        = 1'b1;
        in_valid     = 1'b0;
        pc           = '0;
        mem_data     = '0;
        mem_rstrb    = '0;
        mem_shamt    = '0;
        alu_out      = '0;
        reg_wen      = 1'b0;
        rd_addr      = '0;
        regin_sel    = '0;
        inst_debug   = '0;
        bubble_debug = 1'b0;
        rs_addr      = '0;
        lcg_state    = 32'h40f91bfc;
        for (int r = 0; r < 32; r++) shadow[r] = 64'd0;
        repeat (3) @(posedge I_sys_clk);
        I_rst <= 1'b0;
        test_reset_state();
        test_alu_writeback();
        test_load_align();
        test_link_and_x0();
        test_back_to_back_and_bubbles();
        $display("Test OK");
        $finish;
    end

endmodule
